//--- list.f
logic/mmu_pkg.sv
logic/sram_1r1w.sv
logic/tlb.sv
logic/tlb_miss_walker.sv
logic/page_table_arbiter.sv
logic/page_table_memory.sv
logic/mmu_top.sv
verification/mmu_tb.sv

//--- logic/mmu_pkg.sv
// MMU shared definitions
// Page widths, TLB geometry and the command and walker state encodings
`default_nettype none

package mmu_pkg;
	// Virtual and physical page numbers
	localparam int VPAGE_BITS = 8;
	localparam int PPAGE_BITS = 8;

	// PTE is the valid bit on top of the physical page
	localparam int PTE_BITS = PPAGE_BITS + 1;

	// Flat table, one entry per virtual page
	localparam int PT_ENTRIES = 1 << VPAGE_BITS;

	// Per-client TLB geometry
	localparam int TLB_ENTRIES = 16;
	localparam int TLB_WAYS = 4;
	localparam int TLB_SETS = TLB_ENTRIES / TLB_WAYS;
	// Set index comes from the low virtual page bits
	localparam int SET_IDX_BITS = $clog2(TLB_SETS);

	// Client command opcodes
	typedef enum logic [1:0] {
		OP_TRANSLATE = 2'd0,
		OP_INVALIDATE = 2'd1,
		OP_FLUSH = 2'd2
	} mmu_op_e;

	// Miss walker states
	typedef enum logic [2:0] {
		S_IDLE = 3'd0,
		S_LOOKUP = 3'd1,
		S_WALK_REQ = 3'd2,
		S_WALK_WAIT = 3'd3,
		S_FILL = 3'd4,
		S_RESPOND = 3'd5
	} walk_state_e;
endpackage

`default_nettype wire

//--- logic/mmu_top.sv
// Address translation unit top
// Ifetch and dmem client paths sharing one arbitrated page table
`timescale 1ns/1ns
`default_nettype none

module mmu_top
	import mmu_pkg::*;
(
	input logic clk,
	input logic reset,
	// Ifetch client
	input logic ifetch_req_valid,
	input mmu_op_e ifetch_req_op,
	input logic [VPAGE_BITS-1:0] ifetch_req_vpage,
	output logic ifetch_req_ready,
	output logic ifetch_resp_valid,
	output logic [PPAGE_BITS-1:0] ifetch_resp_ppage,
	output logic ifetch_resp_fault,
	input logic ifetch_resp_ready,
	// Dmem client
	input logic dmem_req_valid,
	input mmu_op_e dmem_req_op,
	input logic [VPAGE_BITS-1:0] dmem_req_vpage,
	output logic dmem_req_ready,
	output logic dmem_resp_valid,
	output logic [PPAGE_BITS-1:0] dmem_resp_ppage,
	output logic dmem_resp_fault,
	input logic dmem_resp_ready,
	// Host table writes
	input logic pt_write_en,
	input logic [VPAGE_BITS-1:0] pt_write_vpage,
	input logic pt_write_valid,
	input logic [PPAGE_BITS-1:0] pt_write_ppage
);
	// Walker 0 is ifetch, walker 1 is dmem
	logic [1:0] walk_valid;
	logic [1:0] walk_ready;
	logic [1:0] walk_rvalid;
	logic [VPAGE_BITS-1:0] walk_vpage [2];
	logic [PTE_BITS-1:0] walk_pte;
	logic rd_en;
	logic [VPAGE_BITS-1:0] rd_vpage;
	logic [PTE_BITS-1:0] rd_pte;

	tlb_miss_walker u_ifetch_walker (
		.clk(clk),
		.reset(reset),
		.req_valid(ifetch_req_valid),
		.req_op(ifetch_req_op),
		.req_vpage(ifetch_req_vpage),
		.req_ready(ifetch_req_ready),
		.resp_valid(ifetch_resp_valid),
		.resp_ppage(ifetch_resp_ppage),
		.resp_fault(ifetch_resp_fault),
		.resp_ready(ifetch_resp_ready),
		.walk_valid(walk_valid[0]),
		.walk_vpage(walk_vpage[0]),
		.walk_ready(walk_ready[0]),
		.walk_rvalid(walk_rvalid[0]),
		.walk_pte(walk_pte)
	);

	tlb_miss_walker u_dmem_walker (
		.clk(clk),
		.reset(reset),
		.req_valid(dmem_req_valid),
		.req_op(dmem_req_op),
		.req_vpage(dmem_req_vpage),
		.req_ready(dmem_req_ready),
		.resp_valid(dmem_resp_valid),
		.resp_ppage(dmem_resp_ppage),
		.resp_fault(dmem_resp_fault),
		.resp_ready(dmem_resp_ready),
		.walk_valid(walk_valid[1]),
		.walk_vpage(walk_vpage[1]),
		.walk_ready(walk_ready[1]),
		.walk_rvalid(walk_rvalid[1]),
		.walk_pte(walk_pte)
	);

	page_table_arbiter u_arbiter (
		.clk(clk),
		.reset(reset),
		.walk_valid(walk_valid),
		.walk_vpage(walk_vpage),
		.walk_ready(walk_ready),
		.walk_rvalid(walk_rvalid),
		.walk_pte(walk_pte),
		.rd_en(rd_en),
		.rd_vpage(rd_vpage),
		.rd_pte(rd_pte)
	);

	page_table_memory u_page_table (
		.clk(clk),
		.reset(reset),
		.pt_write_en(pt_write_en),
		.pt_write_vpage(pt_write_vpage),
		.pt_write_valid(pt_write_valid),
		.pt_write_ppage(pt_write_ppage),
		.rd_en(rd_en),
		.rd_vpage(rd_vpage),
		.rd_pte(rd_pte)
	);
endmodule

`default_nettype wire

//--- logic/page_table_arbiter.sv
// Round-robin arbiter for the page table read port
// Grants one walker per cycle and steers the read strobe back to it
`timescale 1ns/1ns
`default_nettype none

module page_table_arbiter
	import mmu_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic [1:0] walk_valid,
	input logic [VPAGE_BITS-1:0] walk_vpage [2],
	output logic [1:0] walk_ready,
	output logic [1:0] walk_rvalid,
	output logic [PTE_BITS-1:0] walk_pte,
	output logic rd_en,
	output logic [VPAGE_BITS-1:0] rd_vpage,
	input logic [PTE_BITS-1:0] rd_pte
);
	logic [1:0] grant;
	// Index of the walker granted last
	logic last_grant;
	// Grant of the read in flight
	logic [1:0] grant_q;

	// Priority goes to whoever was not granted last
	assign grant[0] = walk_valid[0] && (!walk_valid[1] || last_grant);
	assign grant[1] = walk_valid[1] && (!walk_valid[0] || !last_grant);
	assign walk_ready = grant;

	assign rd_en = |grant;
	assign rd_vpage = grant[1] ? walk_vpage[1] : walk_vpage[0];

	// Read data is shared and the strobe picks the owner
	assign walk_pte = rd_pte;
	assign walk_rvalid = grant_q;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			last_grant <= 1'b1;
			grant_q <= '0;
		end
		else
		begin
			grant_q <= grant;
			if (|grant)
				last_grant <= grant[1];
		end
	end

	// A walker that loses once wins on its next try
	a_no_starve_0: assert property (@(posedge clk) disable iff (reset)
		walk_valid[0] && grant[1] |=> !walk_valid[0] || grant[0]);

	a_no_starve_1: assert property (@(posedge clk) disable iff (reset)
		walk_valid[1] && grant[0] |=> !walk_valid[1] || grant[1]);
endmodule

`default_nettype wire

//--- logic/page_table_memory.sv
// Flat single-level page table
// Host write port plus one read port, unwritten entries read as invalid
`timescale 1ns/1ns
`default_nettype none

module page_table_memory
	import mmu_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic pt_write_en,
	input logic [VPAGE_BITS-1:0] pt_write_vpage,
	input logic pt_write_valid,
	input logic [PPAGE_BITS-1:0] pt_write_ppage,
	input logic rd_en,
	input logic [VPAGE_BITS-1:0] rd_vpage,
	output logic [PTE_BITS-1:0] rd_pte
);
	// Marks entries written since reset
	logic [PT_ENTRIES-1:0] entry_written;
	logic written_q;
	logic [PTE_BITS-1:0] ram_rdata;

	sram_1r1w #(
		.SIZE(PT_ENTRIES),
		.DATA_WIDTH(PTE_BITS)
	) u_pte_ram (
		.clk(clk),
		.read_en(rd_en),
		.read_addr(rd_vpage),
		.read_data(ram_rdata),
		.write_en(pt_write_en),
		.write_addr(pt_write_vpage),
		.write_data({pt_write_valid, pt_write_ppage})
	);

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			entry_written <= '0;
			written_q <= 1'b0;
		end
		else
		begin
			if (pt_write_en)
				entry_written[pt_write_vpage] <= 1'b1;
			// Same bypass as the RAM for a write to the read page
			if (rd_en)
				written_q <= entry_written[rd_vpage] || (pt_write_en && pt_write_vpage == rd_vpage);
		end
	end

	// RAM content is unknown until written, so gate its valid bit
	assign rd_pte = {written_q & ram_rdata[PPAGE_BITS], ram_rdata[PPAGE_BITS-1:0]};
endmodule

`default_nettype wire

//--- logic/sram_1r1w.sv
// Synchronous RAM, one read port and one write port
// Registered read, same-address read during write returns the new data
`timescale 1ns/1ns
`default_nettype none

module sram_1r1w #(
	parameter int SIZE = 16,
	parameter int DATA_WIDTH = 8
) (
	input logic clk,
	input logic read_en,
	input logic [$clog2(SIZE)-1:0] read_addr,
	output logic [DATA_WIDTH-1:0] read_data,
	input logic write_en,
	input logic [$clog2(SIZE)-1:0] write_addr,
	input logic [DATA_WIDTH-1:0] write_data
);
	logic [DATA_WIDTH-1:0] mem [SIZE];

	always_ff @(posedge clk)
	begin
		if (write_en)
			mem[write_addr] <= write_data;

		if (read_en)
		begin
			// Forward write data on collision
			if (write_en && write_addr == read_addr)
				read_data <= write_data;
			else
				read_data <= mem[read_addr];
		end
	end
endmodule

`default_nettype wire

//--- logic/tlb.sv
// Four-way set-associative TLB
// Stage 1 reads the set, stage 2 compares tags and writes fills or invalidates
`timescale 1ns/1ns
`default_nettype none

module tlb
	import mmu_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic lookup_en,
	input logic update_en,
	input logic invalidate_en,
	input logic invalidate_all_en,
	input logic [VPAGE_BITS-1:0] request_vpage_idx,
	input logic [PPAGE_BITS-1:0] update_ppage_idx,
	output logic [PPAGE_BITS-1:0] lookup_ppage_idx,
	output logic lookup_hit
);
	logic tlb_read_en;
	logic [SET_IDX_BITS-1:0] request_set;
	logic [SET_IDX_BITS-1:0] update_set;
	logic [VPAGE_BITS-1:0] vpage_q;
	logic [PPAGE_BITS-1:0] ppage_q;
	logic update_q;
	logic invalidate_q;
	logic [TLB_WAYS-1:0] way_hit;
	logic [TLB_WAYS-1:0] way_write;
	logic [TLB_WAYS-1:0] victim_way;
	logic [PPAGE_BITS-1:0] way_ppage [TLB_WAYS];

	// Stage 1 set selection
	assign request_set = request_vpage_idx[SET_IDX_BITS-1:0];
	// Stage 2 writes back into the set read last cycle
	assign update_set = vpage_q[SET_IDX_BITS-1:0];
	// Fills and invalidates also need the set, to find a matching way
	assign tlb_read_en = lookup_en | update_en | invalidate_en;

	for (genvar w = 0; w < TLB_WAYS; w++)
	begin : g_way
		logic [VPAGE_BITS+PPAGE_BITS-1:0] way_rdata;
		logic [VPAGE_BITS-1:0] way_tag;
		logic way_valid;
		logic [TLB_SETS-1:0] set_valid;

		// Tag and physical page for this way, one word per set
		sram_1r1w #(
			.SIZE(TLB_SETS),
			.DATA_WIDTH(VPAGE_BITS + PPAGE_BITS)
		) u_way_ram (
			.clk(clk),
			.read_en(tlb_read_en),
			.read_addr(request_set),
			.read_data(way_rdata),
			.write_en(way_write[w]),
			.write_addr(update_set),
			.write_data({vpage_q, ppage_q})
		);

		assign way_tag = way_rdata[VPAGE_BITS+PPAGE_BITS-1:PPAGE_BITS];
		assign way_ppage[w] = way_rdata[PPAGE_BITS-1:0];

		// Valid bits in flops so a flush clears every set at once
		always_ff @(posedge clk or posedge reset)
		begin
			if (reset)
			begin
				set_valid <= '0;
				way_valid <= 1'b0;
			end
			else if (invalidate_all_en)
			begin
				set_valid <= '0;
				way_valid <= 1'b0;
			end
			else
			begin
				// Fill sets the bit, invalidate clears it
				if (way_write[w])
					set_valid[update_set] <= update_q;

				if (tlb_read_en)
				begin
					// Same-set write lands this cycle, take its bit
					if (way_write[w] && update_set == request_set)
						way_valid <= update_q;
					else
						way_valid <= set_valid[request_set];
				end
			end
		end

		assign way_hit[w] = way_valid && way_tag == vpage_q;
	end

	// Stage 1 to stage 2 command state
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			update_q <= 1'b0;
			invalidate_q <= 1'b0;
		end
		else
		begin
			update_q <= update_en;
			invalidate_q <= invalidate_en;
		end
	end

	// Request payload
	always_ff @(posedge clk)
	begin
		if (tlb_read_en)
			vpage_q <= request_vpage_idx;
		if (update_en)
			ppage_q <= update_ppage_idx;
	end

	assign lookup_hit = |way_hit;

	// OR mux, hit vector is one-hot so no priority needed
	always_comb
	begin
		lookup_ppage_idx = '0;
		for (int i = 0; i < TLB_WAYS; i++)
		begin
			if (way_hit[i])
				lookup_ppage_idx |= way_ppage[i];
		end
	end

	// Rewrite a matching way, else the victim
	always_comb
	begin
		way_write = '0;
		if (update_q || invalidate_q)
			way_write = lookup_hit ? way_hit : victim_way;
	end

	// Victim pointer rotates when a fill takes it
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			victim_way <= TLB_WAYS'(1);
		else if (update_q && !lookup_hit)
			victim_way <= {victim_way[TLB_WAYS-2:0], victim_way[TLB_WAYS-1]};
	end

	// Walker issues at most one command per cycle
	a_cmd_onehot: assert property (@(posedge clk) disable iff (reset)
		$onehot0({lookup_en, update_en, invalidate_en, invalidate_all_en}));

	// Fills never leave the same page in two ways of a set
	a_hit_onehot: assert property (@(posedge clk) disable iff (reset)
		$onehot0(way_hit));
endmodule

`default_nettype wire

//--- logic/tlb_miss_walker.sv
// Per-client TLB controller
// Accepts commands, looks up its TLB, on a miss walks the page table and fills
`timescale 1ns/1ns
`default_nettype none

module tlb_miss_walker
	import mmu_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic req_valid,
	input mmu_op_e req_op,
	input logic [VPAGE_BITS-1:0] req_vpage,
	output logic req_ready,
	output logic resp_valid,
	output logic [PPAGE_BITS-1:0] resp_ppage,
	output logic resp_fault,
	input logic resp_ready,
	output logic walk_valid,
	output logic [VPAGE_BITS-1:0] walk_vpage,
	input logic walk_ready,
	input logic walk_rvalid,
	input logic [PTE_BITS-1:0] walk_pte
);
	walk_state_e state;
	mmu_op_e op_q;
	logic [VPAGE_BITS-1:0] vpage_q;
	logic accept;
	logic lookup_en;
	logic update_en;
	logic invalidate_en;
	logic invalidate_all_en;
	logic [VPAGE_BITS-1:0] tlb_vpage;
	logic lookup_hit;
	logic [PPAGE_BITS-1:0] lookup_ppage;
	logic pte_valid;
	logic translate_hit;

	assign req_ready = state == S_IDLE;
	assign accept = req_valid && req_ready;

	// TLB command issued in the acceptance cycle
	assign lookup_en = accept && req_op == OP_TRANSLATE;
	assign invalidate_en = accept && req_op == OP_INVALIDATE;
	assign invalidate_all_en = accept && req_op == OP_FLUSH;
	assign update_en = state == S_FILL;
	// Live page while idle, held page afterwards
	assign tlb_vpage = (state == S_IDLE) ? req_vpage : vpage_q;

	assign walk_valid = state == S_WALK_REQ;
	assign walk_vpage = vpage_q;
	assign pte_valid = walk_pte[PPAGE_BITS];
	// Hit only counts for a translate
	assign translate_hit = state == S_LOOKUP && op_q == OP_TRANSLATE && lookup_hit;

	tlb u_tlb (
		.clk(clk),
		.reset(reset),
		.lookup_en(lookup_en),
		.update_en(update_en),
		.invalidate_en(invalidate_en),
		.invalidate_all_en(invalidate_all_en),
		.request_vpage_idx(tlb_vpage),
		.update_ppage_idx(resp_ppage),
		.lookup_ppage_idx(lookup_ppage),
		.lookup_hit(lookup_hit)
	);

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state <= S_IDLE;
			resp_valid <= 1'b0;
		end
		else
		begin
			case (state)
				S_IDLE:
					if (accept)
						state <= S_LOOKUP;
				S_LOOKUP:
					// Invalidate and flush finish here with no response
					if (op_q != OP_TRANSLATE)
						state <= S_IDLE;
					else if (lookup_hit)
					begin
						resp_valid <= 1'b1;
						state <= S_RESPOND;
					end
					else
						state <= S_WALK_REQ;
				S_WALK_REQ:
					if (walk_ready)
						state <= S_WALK_WAIT;
				S_WALK_WAIT:
					if (walk_rvalid)
					begin
						if (pte_valid)
							state <= S_FILL;
						else
						begin
							// Faults are answered, never cached
							resp_valid <= 1'b1;
							state <= S_RESPOND;
						end
					end
				S_FILL:
				begin
					resp_valid <= 1'b1;
					state <= S_RESPOND;
				end
				S_RESPOND:
					if (resp_ready)
					begin
						resp_valid <= 1'b0;
						state <= S_IDLE;
					end
				default:
					state <= S_IDLE;
			endcase
		end
	end

	// Command and response payload
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			op_q <= req_op;
			vpage_q <= req_vpage;
		end

		if (translate_hit)
		begin
			resp_ppage <= lookup_ppage;
			resp_fault <= 1'b0;
		end
		else if (state == S_WALK_WAIT && walk_rvalid)
		begin
			// Also the fill data for S_FILL
			resp_ppage <= walk_pte[PPAGE_BITS-1:0];
			resp_fault <= !pte_valid;
		end
	end

	// Arbiter returns data only to the walker it granted
	a_rvalid_in_wait: assert property (@(posedge clk) disable iff (reset)
		walk_rvalid |-> state == S_WALK_WAIT);

	// Response held until the client takes it
	a_resp_stable: assert property (@(posedge clk) disable iff (reset)
		resp_valid && !resp_ready |=> resp_valid && $stable(resp_ppage) && $stable(resp_fault));
endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build and run the MMU testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module mmu_tb -o mmu_sim

output=$(./obj_dir/mmu_sim)
echo "$output"

if echo "$output" | grep -qx "Result: PASSED"; then
	exit 0
fi
exit 1

//--- verification/mmu_tb.sv
// MMU testbench
// Random table fills and translates on both clients, checked against a page table model
`timescale 1ns/1ns
`default_nettype none

module mmu_tb
	import mmu_pkg::*;
();
	// Cached pages per client, one per TLB set
	localparam int N_PAGES = 4;
	// Random translates per client in the concurrent test
	localparam int N_RANDOM = 40;
	// Rough bound on one translate with arbitration
	localparam int MISS_CYCLES = 12;
	// Test lengths summed in order, fill+miss, hit, fault, invalidate, flush, concurrent
	localparam int TEST_CYCLES = 2 * PT_ENTRIES + 2 * N_PAGES * MISS_CYCLES
		+ 2 * N_PAGES * MISS_CYCLES + 8 * MISS_CYCLES
		+ 2 * (6 + N_PAGES * MISS_CYCLES)
		+ 2 * PT_ENTRIES + 2 * N_PAGES * MISS_CYCLES
		+ 4 * N_RANDOM * MISS_CYCLES;
	localparam int CYCLE_LIMIT = 4 * TEST_CYCLES;

	logic clk;
	logic reset;
	// Index 0 is ifetch, index 1 is dmem
	logic [1:0] req_valid;
	mmu_op_e req_op [2];
	logic [VPAGE_BITS-1:0] req_vpage [2];
	logic [1:0] req_ready;
	logic [1:0] resp_valid;
	logic [PPAGE_BITS-1:0] resp_ppage [2];
	logic [1:0] resp_fault;
	logic [1:0] resp_ready;
	logic pt_write_en;
	logic [VPAGE_BITS-1:0] pt_write_vpage;
	logic pt_write_valid;
	logic [PPAGE_BITS-1:0] pt_write_ppage;

	// Reference page table, mirrors every host write
	logic model_valid [PT_ENTRIES];
	logic [PPAGE_BITS-1:0] model_ppage [PT_ENTRIES];
	logic [VPAGE_BITS-1:0] pages [2][N_PAGES];
	string test_name;
	int checks = 0;
	int errors = 0;
	int checks_at_start;
	int errors_at_start;
	int cycle_count = 0;

	mmu_top uut (
		.clk(clk),
		.reset(reset),
		.ifetch_req_valid(req_valid[0]),
		.ifetch_req_op(req_op[0]),
		.ifetch_req_vpage(req_vpage[0]),
		.ifetch_req_ready(req_ready[0]),
		.ifetch_resp_valid(resp_valid[0]),
		.ifetch_resp_ppage(resp_ppage[0]),
		.ifetch_resp_fault(resp_fault[0]),
		.ifetch_resp_ready(resp_ready[0]),
		.dmem_req_valid(req_valid[1]),
		.dmem_req_op(req_op[1]),
		.dmem_req_vpage(req_vpage[1]),
		.dmem_req_ready(req_ready[1]),
		.dmem_resp_valid(resp_valid[1]),
		.dmem_resp_ppage(resp_ppage[1]),
		.dmem_resp_fault(resp_fault[1]),
		.dmem_resp_ready(resp_ready[1]),
		.pt_write_en(pt_write_en),
		.pt_write_vpage(pt_write_vpage),
		.pt_write_valid(pt_write_valid),
		.pt_write_ppage(pt_write_ppage)
	);

	always #10 clk = ~clk;

	// Hang guard
	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count > CYCLE_LIMIT)
		begin
			$display("Timeout after %0d cycles, a client never finished its handshake",
				cycle_count);
			$display("Result: FAILED");
			$finish;
		end
	end

	task automatic check_ppage(input string what, input logic [PPAGE_BITS-1:0] expected,
		input logic [PPAGE_BITS-1:0] actual);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("FAILED %s %s ppage: expected %02h, actual %02h",
				test_name, what, expected, actual);
		end
	endtask

	task automatic check_fault(input string what, input logic expected, input logic actual);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("FAILED %s %s fault: expected %0b, actual %0b",
				test_name, what, expected, actual);
		end
	endtask

	task automatic check_latency(input string what, input int expected, input int actual);
		checks++;
		if (actual != expected)
		begin
			errors++;
			$display("FAILED %s %s latency: expected %0d, actual %0d",
				test_name, what, expected, actual);
		end
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		checks_at_start = checks;
		errors_at_start = errors;
	endtask

	task automatic end_test();
		$display("test %s: %0d checks, %0d errors", test_name,
			checks - checks_at_start, errors - errors_at_start);
	endtask

	// Host write, one cycle on the port
	task automatic write_pte(input logic [VPAGE_BITS-1:0] vpage, input logic valid,
		input logic [PPAGE_BITS-1:0] ppage);
		@(posedge clk);
		pt_write_en <= 1'b1;
		pt_write_vpage <= vpage;
		pt_write_valid <= valid;
		pt_write_ppage <= ppage;
		@(posedge clk);
		pt_write_en <= 1'b0;
		model_valid[vpage] = valid;
		model_ppage[vpage] = ppage;
	endtask

	// Present a command and return on the edge that accepts it
	task automatic issue(input bit c, input mmu_op_e op, input logic [VPAGE_BITS-1:0] vpage);
		@(posedge clk);
		req_valid[c] <= 1'b1;
		req_op[c] <= op;
		req_vpage[c] <= vpage;
		do
			@(posedge clk);
		while (!req_ready[c]);
		req_valid[c] <= 1'b0;
	endtask

	// Invalidate or flush, done once the walker is idle again
	task automatic send_command(input bit c, input mmu_op_e op,
		input logic [VPAGE_BITS-1:0] vpage);
		issue(c, op, vpage);
		do
			@(posedge clk);
		while (!req_ready[c]);
	endtask

	// Latency counts edges from acceptance to the first sampled resp_valid
	task automatic translate(input bit c, input logic [VPAGE_BITS-1:0] vpage, input bit stall,
		output logic [PPAGE_BITS-1:0] ppage, output logic fault, output int latency);
		int n;
		logic done;
		issue(c, OP_TRANSLATE, vpage);
		n = 0;
		latency = 0;
		do
		begin
			@(posedge clk);
			n++;
			if (resp_valid[c] && latency == 0)
				latency = n;
			done = resp_valid[c] && resp_ready[c];
			// Random back-pressure, ready about one cycle in three
			if (stall && !done)
				resp_ready[c] <= $urandom % 3 == 0;
		end
		while (!done);
		ppage = resp_ppage[c];
		fault = resp_fault[c];
		resp_ready[c] <= 1'b1;
	endtask

	// Expected result straight from the model entry
	task automatic check_translate(input bit c, input logic [VPAGE_BITS-1:0] vpage,
		input bit stall, output int latency);
		logic [PPAGE_BITS-1:0] ppage;
		logic fault;
		string what;
		what = $sformatf("client %0d page %02h", c, vpage);
		translate(c, vpage, stall, ppage, fault, latency);
		check_fault(what, !model_valid[vpage], fault);
		if (model_valid[vpage])
			check_ppage(what, model_ppage[vpage], ppage);
	endtask

	task automatic random_traffic(input bit c);
		int latency;
		for (int n = 0; n < N_RANDOM; n++)
			check_translate(c, VPAGE_BITS'($urandom), 1'b1, latency);
	endtask

	initial
	begin
		int latency;
		logic [VPAGE_BITS-1:0] vp;
		void'($urandom(26));
		clk = 1'b0;
		reset = 1'b1;
		req_valid = '0;
		resp_ready = '1;
		pt_write_en = 1'b0;
		pt_write_vpage = '0;
		pt_write_valid = 1'b0;
		pt_write_ppage = '0;
		for (int i = 0; i < 2; i++)
		begin
			req_op[i] = OP_TRANSLATE;
			req_vpage[i] = '0;
		end
		for (int v = 0; v < PT_ENTRIES; v++)
		begin
			model_valid[v] = 1'b0;
			model_ppage[v] = '0;
		end
		repeat (5) @(posedge clk);
		reset <= 1'b0;

		// Pages below 192 mapped, 192 to 223 written invalid, the rest never written
		begin_test("fill_miss");
		for (int v = 0; v < 224; v++)
			write_pte(VPAGE_BITS'(v), v < 192, PPAGE_BITS'($urandom));
		// Disjoint page ranges per client, page k lands in set k
		for (int i = 0; i < 2; i++)
			for (int k = 0; k < N_PAGES; k++)
			begin
				pages[i][k] = VPAGE_BITS'(96 * i + ($urandom % 24) * 4 + k);
				check_translate(1'(i), pages[i][k], 1'b0, latency);
			end
		end_test();

		begin_test("hit_repeat");
		for (int i = 0; i < 2; i++)
			for (int k = 0; k < N_PAGES; k++)
			begin
				check_translate(1'(i), pages[i][k], 1'b0, latency);
				check_latency($sformatf("client %0d page %02h", i, pages[i][k]), 2, latency);
			end
		end_test();

		// One written-invalid and one unwritten page, each asked twice
		begin_test("fault_repeat");
		for (int i = 0; i < 2; i++)
			for (int j = 0; j < 2; j++)
			begin
				vp = VPAGE_BITS'(192 + 32 * j + $urandom % 32);
				repeat (2) check_translate(1'(i), vp, 1'b0, latency);
			end
		end_test();

		begin_test("remap_invalidate");
		for (int i = 0; i < 2; i++)
		begin
			vp = pages[i][0];
			// Nonzero xor, so the page really changes
			write_pte(vp, 1'b1, model_ppage[vp] ^ PPAGE_BITS'(1 + $urandom % 255));
			send_command(1'(i), OP_INVALIDATE, vp);
			for (int k = 0; k < N_PAGES; k++)
				check_translate(1'(i), pages[i][k], 1'b0, latency);
		end
		end_test();

		begin_test("remap_flush");
		for (int v = 0; v < 192; v++)
			write_pte(VPAGE_BITS'(v), 1'b1, model_ppage[v] ^ PPAGE_BITS'(1 + $urandom % 255));
		send_command(1'b0, OP_FLUSH, '0);
		send_command(1'b1, OP_FLUSH, '0);
		for (int i = 0; i < 2; i++)
			for (int k = 0; k < N_PAGES; k++)
				check_translate(1'(i), pages[i][k], 1'b0, latency);
		end_test();

		// Both walkers compete for the table port
		begin_test("concurrent_random");
		fork
			random_traffic(1'b0);
			random_traffic(1'b1);
		join
		end_test();

		$display("Totals: %0d checks, %0d errors, %0d cycles", checks, errors, cycle_count);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end
endmodule

`default_nettype wire
